// ==== rtl/udp_rx_pkg.sv ====
package udp_rx_pkg;

  localparam int data_w = 64;

  // stream byte n of a beat sits in data[8n+7:8n]
  typedef struct packed {
    logic [data_w-1:0]   data;
    logic [data_w/8-1:0] mask;
    logic                last;
    logic                bad;
  } mac_beat_t;

  // registered beat, its place in the frame and the upper bytes of the beat before it
  typedef struct packed {
    mac_beat_t   cur;
    logic [47:0] prev_hi;
    logic [2:0]  idx;
    logic        sof;
    logic        in_frame;
  } tracked_beat_t;

  typedef struct packed {
    logic decided;
    logic accept;
  } verdict_t;

  typedef struct packed {
    logic [31:0] ip;
    logic [15:0] port;
  } src_info_t;

  // payload word in network order, first byte in bits 63:56
  typedef struct packed {
    logic [data_w-1:0] data;
    logic              eof;
    logic              bad;
    logic              overrun;
    src_info_t         src;
  } fifo_entry_t;

  localparam logic [15:0] ethertype_ipv4   = 16'h0800;
  localparam logic [7:0]  ip_ver_ihl       = 8'h45;
  localparam logic [7:0]  proto_udp        = 8'h11;
  localparam logic [23:0] mcast_mac_prefix = 24'h01005e;

  // first udp payload byte for a 20 byte ip header
  localparam int payload_offset = 42;

endpackage

// ==== rtl/rx_beat_tracker.sv ====
`timescale 1ns/10ps

module rx_beat_tracker (
  input  logic                      mac_clk,
  input  logic                      mac_rst,
  input  udp_rx_pkg::mac_beat_t     mac_rx,
  output udp_rx_pkg::tracked_beat_t beat
);

  // index saturates at the first beat that completes a payload word
  localparam logic [2:0] last_idx = 3'(udp_rx_pkg::payload_offset / 8 + 1);

  udp_rx_pkg::mac_beat_t cur_q;
  logic [47:0]           prev_hi_q;
  logic [2:0]            idx_q;
  logic                  sof_q;
  logic                  in_frame_q;
  logic                  active;
  logic                  present;
  logic                  start;

  assign present = |mac_rx.mask;
  // a frame opens with a full mask while no frame is running
  assign start   = present && (&mac_rx.mask) && !active;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      active     <= 1'b0;
      sof_q      <= 1'b0;
      in_frame_q <= 1'b0;
      idx_q      <= '0;
    end else begin
      sof_q      <= start;
      in_frame_q <= start || (present && active);
      if (start) begin
        idx_q <= '0;
      end else if (present && active && idx_q != last_idx) begin
        idx_q <= idx_q + 3'd1;
      end
      if (present && (start || active)) begin
        active <= !mac_rx.last;
      end
    end
  end

  // keep bytes 2..7 of the last present beat, gaps leave it alone
  always_ff @(posedge mac_clk) begin
    cur_q <= mac_rx;
    if (|cur_q.mask) begin
      prev_hi_q <= cur_q.data[63:16];
    end
  end

  assign beat = '{cur: cur_q, prev_hi: prev_hi_q, idx: idx_q, sof: sof_q, in_frame: in_frame_q};

endmodule

// ==== rtl/eth_addr_filter.sv ====
`timescale 1ns/10ps

module eth_addr_filter (
  input  logic                      mac_clk,
  input  logic                      mac_rst,
  input  udp_rx_pkg::tracked_beat_t beat,
  input  logic [47:0]               local_mac,
  output udp_rx_pkg::verdict_t      verdict
);

  logic [63:0] d;
  logic [47:0] dst_mac;
  logic        mac_ok;

  assign d = beat.cur.data;

  // first byte on the wire is the most significant address byte
  assign dst_mac = {d[7:0], d[15:8], d[23:16], d[31:24], d[39:32], d[47:40]};

  // local, broadcast or ipv4 multicast
  assign mac_ok = (dst_mac == local_mac) ||
                  (dst_mac == {48{1'b1}}) ||
                  (dst_mac[47:24] == udp_rx_pkg::mcast_mac_prefix);

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      verdict <= '0;
    end else if (beat.sof) begin
      verdict <= '{decided: 1'b1, accept: mac_ok};
    end else if (beat.in_frame && beat.cur.last) begin
      // undecided again once the frame is over
      verdict <= '0;
    end
  end

endmodule

// ==== rtl/ip_udp_filter.sv ====
`timescale 1ns/10ps

module ip_udp_filter (
  input  logic                      mac_clk,
  input  logic                      mac_rst,
  input  udp_rx_pkg::tracked_beat_t beat,
  input  logic [31:0]               local_ip,
  input  logic [15:0]               local_port,
  input  logic [31:0]               local_mc_ip,
  input  logic [31:0]               local_mc_mask,
  output udp_rx_pkg::verdict_t      verdict,
  output udp_rx_pkg::src_info_t     src
);

  localparam udp_rx_pkg::verdict_t reject = '{decided: 1'b1, accept: 1'b0};

  logic [63:0] d;
  logic [47:0] p;
  logic [15:0] ethertype;
  logic [31:0] dst_ip;
  logic [15:0] dst_port;
  logic        ip_ok;
  logic [31:0] src_ip_q;
  logic [15:0] src_port_q;

  assign d = beat.cur.data;
  assign p = beat.prev_hi;

  // bytes 12,13 on beat 1
  assign ethertype = {d[39:32], d[47:40]};

  // dst ip is bytes 30..33, the first two sit in the previous beat
  assign dst_ip   = {p[39:32], p[47:40], d[7:0], d[15:8]};
  assign dst_port = {d[39:32], d[47:40]};

  // own address, the group address, or inside the group mask
  assign ip_ok = (dst_ip == local_ip) ||
                 (dst_ip == local_mc_ip) ||
                 ((dst_ip & local_mc_mask) == (local_mc_ip & local_mc_mask));

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      verdict <= '0;
    end else if (beat.in_frame) begin
      if (beat.sof || beat.cur.last) begin
        verdict <= '0;
      end else if (!verdict.decided) begin
        case (beat.idx)
          3'd1: begin
            if (ethertype != udp_rx_pkg::ethertype_ipv4 ||
                d[55:48] != udp_rx_pkg::ip_ver_ihl) begin
              verdict <= reject;
            end
          end
          3'd2: begin
            // protocol is byte 23
            if (d[63:56] != udp_rx_pkg::proto_udp) begin
              verdict <= reject;
            end
          end
          3'd4: begin
            verdict <= '{decided: 1'b1, accept: ip_ok && (dst_port == local_port)};
          end
          default: begin
          end
        endcase
      end
    end
  end

  // source ip is bytes 26..29, source port bytes 34,35
  always_ff @(posedge mac_clk) begin
    if (beat.in_frame && beat.idx == 3'd3) begin
      src_ip_q <= {d[23:16], d[31:24], d[39:32], d[47:40]};
    end
    if (beat.in_frame && beat.idx == 3'd4) begin
      src_port_q <= {d[23:16], d[31:24]};
    end
  end

  assign src = '{ip: src_ip_q, port: src_port_q};

endmodule

// ==== rtl/rx_frame_router.sv ====
`timescale 1ns/10ps

module rx_frame_router (
  input  logic                      mac_clk,
  input  logic                      mac_rst,
  input  udp_rx_pkg::tracked_beat_t beat,
  input  udp_rx_pkg::verdict_t      mac_verdict,
  input  udp_rx_pkg::verdict_t      ip_verdict,
  input  udp_rx_pkg::src_info_t     src,
  input  logic                      local_enable,
  input  logic                      almost_full,
  input  logic                      overrun_ack,
  output logic                      wr_en,
  output udp_rx_pkg::fifo_entry_t   wr_entry
);

  // every beat from here on completes one payload word
  localparam logic [2:0] word_idx = 3'(udp_rx_pkg::payload_offset / 8 + 1);

  typedef enum logic [1:0] {
    st_run,
    st_overrun,
    st_wait_sof
  } state_t;

  state_t      state;
  logic        en_q;
  logic        frame_ok;
  logic        deliver;
  logic [63:0] d;
  logic [47:0] p;
  logic [63:0] word;

  assign d = beat.cur.data;
  assign p = beat.prev_hi;

  // bytes 2..7 of the previous beat then bytes 0..1 of this one
  assign word = {p[7:0], p[15:8], p[23:16], p[31:24], p[39:32], p[47:40], d[7:0], d[15:8]};

  assign frame_ok = mac_verdict.decided && mac_verdict.accept &&
                    ip_verdict.decided && ip_verdict.accept && en_q;

  assign deliver = (state == st_run) && beat.in_frame && (beat.idx == word_idx) && frame_ok;

  // enable is judged once per frame, on the last header beat
  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      en_q <= 1'b0;
    end else if (beat.in_frame && beat.idx == 3'd4) begin
      en_q <= local_enable;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state <= st_run;
      wr_en <= 1'b0;
    end else begin
      wr_en <= deliver;
      case (state)
        st_run: begin
          if (deliver && almost_full) begin
            state <= st_overrun;
          end
        end
        // nothing is written until the application has seen the overrun
        st_overrun: begin
          if (overrun_ack) begin
            state <= st_wait_sof;
          end
        end
        // drop the rest of the frame in flight
        st_wait_sof: begin
          if (beat.sof) begin
            state <= st_run;
          end
        end
        default: begin
          state <= st_run;
        end
      endcase
    end
  end

  // a last beat longer than two bytes has its extra bytes dropped
  always_ff @(posedge mac_clk) begin
    if (deliver) begin
      wr_entry <= '{data: word,
                    eof: beat.cur.last || almost_full,
                    bad: beat.cur.last && beat.cur.bad,
                    overrun: almost_full,
                    src: src};
    end
  end

endmodule

// ==== rtl/rx_packet_fifo.sv ====
`timescale 1ns/10ps

module rx_packet_fifo #(
  parameter int depth              = 32,
  parameter int almost_full_margin = 4
) (
  input  logic                    mac_clk,
  input  logic                    mac_rst,
  input  logic                    wr_en,
  input  udp_rx_pkg::fifo_entry_t wr_entry,
  input  logic                    rd_en,
  output udp_rx_pkg::fifo_entry_t rd_entry,
  output logic                    empty,
  output logic                    almost_full
);

  localparam int aw = $clog2(depth);
  localparam int cw = $clog2(depth + 1);

  udp_rx_pkg::fifo_entry_t mem [depth];

  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [cw-1:0] count;
  logic          do_wr;
  logic          do_rd;

  // pops on an empty fifo and pushes on a full one are ignored
  assign do_rd = rd_en && (count != '0);
  assign do_wr = wr_en && (count != cw'(depth));

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry is visible without a read
  assign rd_entry = mem[rd_ptr];
  assign empty    = (count == '0);

  // fewer than almost_full_margin free slots
  assign almost_full = (count > cw'(depth - almost_full_margin));

endmodule

// ==== rtl/udp_rx.sv ====
`timescale 1ns/10ps

module udp_rx #(
  parameter int fifo_depth         = 32,
  parameter int almost_full_margin = 4
) (
  input  logic                    mac_clk,
  input  logic                    mac_rst,
  input  udp_rx_pkg::mac_beat_t   mac_rx,
  input  logic                    local_enable,
  input  logic [47:0]             local_mac,
  input  logic [31:0]             local_ip,
  input  logic [15:0]             local_port,
  input  logic [31:0]             local_mc_ip,
  input  logic [31:0]             local_mc_mask,
  output logic                    app_rx_valid,
  output udp_rx_pkg::fifo_entry_t app_rx,
  input  logic                    app_rx_ack,
  input  logic                    app_rx_overrun_ack
);

  udp_rx_pkg::tracked_beat_t beat;
  udp_rx_pkg::verdict_t      mac_verdict;
  udp_rx_pkg::verdict_t      ip_verdict;
  udp_rx_pkg::src_info_t     src;
  udp_rx_pkg::fifo_entry_t   wr_entry;
  logic                      wr_en;
  logic                      almost_full;
  logic                      fifo_empty;

  rx_beat_tracker i_tracker (
    .mac_clk (mac_clk),
    .mac_rst (mac_rst),
    .mac_rx  (mac_rx),
    .beat    (beat)
  );

  eth_addr_filter i_eth_filter (
    .mac_clk   (mac_clk),
    .mac_rst   (mac_rst),
    .beat      (beat),
    .local_mac (local_mac),
    .verdict   (mac_verdict)
  );

  ip_udp_filter i_ip_filter (
    .mac_clk       (mac_clk),
    .mac_rst       (mac_rst),
    .beat          (beat),
    .local_ip      (local_ip),
    .local_port    (local_port),
    .local_mc_ip   (local_mc_ip),
    .local_mc_mask (local_mc_mask),
    .verdict       (ip_verdict),
    .src           (src)
  );

  rx_frame_router i_router (
    .mac_clk      (mac_clk),
    .mac_rst      (mac_rst),
    .beat         (beat),
    .mac_verdict  (mac_verdict),
    .ip_verdict   (ip_verdict),
    .src          (src),
    .local_enable (local_enable),
    .almost_full  (almost_full),
    .overrun_ack  (app_rx_overrun_ack),
    .wr_en        (wr_en),
    .wr_entry     (wr_entry)
  );

  rx_packet_fifo #(
    .depth              (fifo_depth),
    .almost_full_margin (almost_full_margin)
  ) i_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (wr_en),
    .wr_entry    (wr_entry),
    .rd_en       (app_rx_ack),
    .rd_entry    (app_rx),
    .empty       (fifo_empty),
    .almost_full (almost_full)
  );

  assign app_rx_valid = !fifo_empty;

endmodule

// ==== tests/udp_rx_properties.sv ====
`timescale 1ns/10ps

module udp_rx_properties (
  input logic                    mac_clk,
  input logic                    mac_rst,
  input logic                    app_rx_valid,
  input udp_rx_pkg::fifo_entry_t app_rx,
  input logic                    app_rx_ack,
  input udp_rx_pkg::verdict_t    mac_verdict,
  input udp_rx_pkg::verdict_t    ip_verdict
);

  // failed assertions so far, watched by the testbench
  int unsigned fail_count = 0;
  logic        seen_accept;

  // some frame has passed both filters since reset
  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      seen_accept <= 1'b0;
    end else if (mac_verdict.decided && mac_verdict.accept &&
                 ip_verdict.decided && ip_verdict.accept) begin
      seen_accept <= 1'b1;
    end
  end

  valid_low_in_reset: assert property (@(posedge mac_clk) mac_rst |=> !app_rx_valid)
    else begin
      $error("app_rx_valid high during or just after reset");
      fail_count++;
    end

  head_stable: assert property (@(posedge mac_clk) disable iff (mac_rst)
    app_rx_valid && !app_rx_ack |=> $stable(app_rx))
    else begin
      $error("app_rx changed while valid and not acknowledged");
      fail_count++;
    end

  overrun_has_eof: assert property (@(posedge mac_clk) disable iff (mac_rst)
    app_rx_valid && app_rx.overrun |-> app_rx.eof)
    else begin
      $error("overrun entry without eof");
      fail_count++;
    end

  valid_needs_frame: assert property (@(posedge mac_clk) disable iff (mac_rst)
    app_rx_valid |-> seen_accept)
    else begin
      $error("app_rx_valid before any frame was accepted");
      fail_count++;
    end

endmodule

bind udp_rx udp_rx_properties i_props (
  .mac_clk      (mac_clk),
  .mac_rst      (mac_rst),
  .app_rx_valid (app_rx_valid),
  .app_rx       (app_rx),
  .app_rx_ack   (app_rx_ack),
  .mac_verdict  (mac_verdict),
  .ip_verdict   (ip_verdict)
);

// ==== tests/udp_rx_tb.sv ====
`timescale 1ns/10ps

module udp_rx_tb;

  localparam int fifo_depth = 32;
  localparam int af_margin  = 4;
  localparam int hdr_bytes  = 42;
  // about 20 frames of at most 16 beats, ten cycles per beat for slow acks and drains
  localparam int timeout_cycles = 20 * 16 * 10;

  localparam logic [47:0] my_mac  = 48'h02_11_22_33_44_55;
  localparam logic [31:0] my_ip   = 32'hc0a8_0a02;
  localparam logic [15:0] my_port = 16'd5001;
  localparam logic [31:0] mc_ip   = 32'hef01_0000;
  localparam logic [31:0] mc_mask = 32'hffff_0000;

  typedef struct packed {
    logic [47:0] dmac;
    logic [15:0] etype;
    logic [7:0]  ver;
    logic [7:0]  proto;
    logic [31:0] dip;
    logic [15:0] dport;
  } hdr_t;

  logic                    mac_clk = 1'b0;
  logic                    mac_rst;
  udp_rx_pkg::mac_beat_t   mac_rx;
  logic                    local_enable;
  logic                    app_rx_valid;
  udp_rx_pkg::fifo_entry_t app_rx;
  logic                    app_rx_ack;
  logic                    app_rx_overrun_ack;

  udp_rx_pkg::fifo_entry_t expect_q [$];
  int cycles = 0;
  int popped = 0;
  bit consume = 1'b0;
  bit overrun_allowed = 1'b0;
  bit overrun_seen = 1'b0;
  hdr_t good;
  hdr_t h;

  udp_rx #(
    .fifo_depth         (fifo_depth),
    .almost_full_margin (af_margin)
  ) i_dut (
    .mac_clk            (mac_clk),
    .mac_rst            (mac_rst),
    .mac_rx             (mac_rx),
    .local_enable       (local_enable),
    .local_mac          (my_mac),
    .local_ip           (my_ip),
    .local_port         (my_port),
    .local_mc_ip        (mc_ip),
    .local_mc_mask      (mc_mask),
    .app_rx_valid       (app_rx_valid),
    .app_rx             (app_rx),
    .app_rx_ack         (app_rx_ack),
    .app_rx_overrun_ack (app_rx_overrun_ack)
  );

  always #2 mac_clk = ~mac_clk;

  always @(posedge mac_clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout, run took more than %0d cycles", timeout_cycles);
      $display("Simulation failed");
      $fatal(1);
    end else if (i_dut.i_props.fail_count != 0) begin
      $display("a bound assertion on udp_rx failed at %0t", $time);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // entry about to be popped against the head of the expected queue
  task automatic check_entry(input udp_rx_pkg::fifo_entry_t got);
    udp_rx_pkg::fifo_entry_t exp;
    entry_expected: assert (expect_q.size() != 0) else begin
      $display("unexpected entry on app_rx at %0t, no payload was pending", $time);
      $display("Simulation failed");
      $fatal(1);
    end
    exp = expect_q.pop_front();
    data_ok: assert (got.data == exp.data) else fail_value("app_rx.data", got.data, exp.data);
    src_ip_ok: assert (got.src.ip == exp.src.ip)
      else fail_value("app_rx.src.ip", 64'(got.src.ip), 64'(exp.src.ip));
    src_port_ok: assert (got.src.port == exp.src.port)
      else fail_value("app_rx.src.port", 64'(got.src.port), 64'(exp.src.port));
    if (got.overrun) begin
      overrun_ok: assert (overrun_allowed && got.eof) else begin
        $display("overrun entry at %0t outside the overrun test or without eof", $time);
        $display("Simulation failed");
        $fatal(1);
      end
      overrun_late: assert (popped >= fifo_depth - af_margin)
        else fail_value("entries before overrun", 64'(popped), 64'(fifo_depth - af_margin));
      overrun_seen = 1'b1;
      // the rest of the buffered frames is lost
      expect_q.delete();
    end else begin
      eof_ok: assert (got.eof == exp.eof) else fail_value("app_rx.eof", 64'(got.eof), 64'(exp.eof));
      bad_ok: assert (got.bad == exp.bad) else fail_value("app_rx.bad", 64'(got.bad), 64'(exp.bad));
    end
    popped++;
  endtask

  // random acks, the entry shown is checked when it is acked
  always @(posedge mac_clk) begin
    #1;
    if (consume && app_rx_valid && $urandom_range(3) != 0) begin
      check_entry(app_rx);
      app_rx_ack = 1'b1;
    end else begin
      app_rx_ack = 1'b0;
    end
  end

  // frame of 42 + 8*words bytes, last beat holds two bytes
  task automatic send_frame(input hdr_t hd, input int words, input bit bad_end, input bit deliver);
    logic [7:0]              b [];
    logic [31:0]             sip;
    logic [15:0]             sport;
    udp_rx_pkg::fifo_entry_t e;
    udp_rx_pkg::mac_beat_t   mb;
    int                      nbytes;
    int                      nbeats;
    int                      i;
    int                      j;
    nbytes = hdr_bytes + 8 * words;
    nbeats = (nbytes + 7) / 8;
    b = new[nbytes];
    foreach (b[n]) b[n] = 8'($urandom);
    sip = $urandom;
    sport = 16'($urandom);
    for (i = 0; i < 6; i++) begin
      b[i] = hd.dmac[47-8*i -: 8];
    end
    b[12] = hd.etype[15:8];
    b[13] = hd.etype[7:0];
    b[14] = hd.ver;
    b[23] = hd.proto;
    for (i = 0; i < 4; i++) begin
      b[26+i] = sip[31-8*i -: 8];
      b[30+i] = hd.dip[31-8*i -: 8];
    end
    b[34] = sport[15:8];
    b[35] = sport[7:0];
    b[36] = hd.dport[15:8];
    b[37] = hd.dport[7:0];
    if (deliver) begin
      for (i = 0; i < words; i++) begin
        e = '0;
        for (j = 0; j < 8; j++) begin
          e.data = {e.data[55:0], b[hdr_bytes + 8*i + j]};
        end
        e.eof = (i == words - 1);
        e.bad = e.eof && bad_end;
        e.src = '{ip: sip, port: sport};
        expect_q.push_back(e);
      end
    end
    for (i = 0; i < nbeats; i++) begin
      mb = '0;
      for (j = 0; j < 8; j++) begin
        if (8*i + j < nbytes) begin
          mb.data[8*j +: 8] = b[8*i + j];
          mb.mask[j] = 1'b1;
        end
      end
      mb.last = (i == nbeats - 1);
      mb.bad = mb.last && bad_end;
      @(posedge mac_clk);
      #1;
      mac_rx = mb;
    end
    @(posedge mac_clk);
    #1;
    mac_rx = '0;
  endtask

  task automatic wait_drain();
    while (expect_q.size() != 0 || app_rx_valid) begin
      @(posedge mac_clk);
    end
    // room for a stray write to show up
    repeat (8) @(posedge mac_clk);
  endtask

  function automatic hdr_t corrupt(input hdr_t hd, input int which);
    hdr_t r;
    r = hd;
    case (which)
      0: r.dmac = 48'h02_11_22_33_44_66;
      1: r.etype = 16'h86dd;
      2: r.ver = 8'h46;
      3: r.proto = 8'h06;
      4: r.dport = hd.dport + 16'd1;
      default: r.dip = 32'hc0a8_0a63;
    endcase
    return r;
  endfunction

  initial begin
    void'($urandom(32'h5ba6_4202));
    mac_rst = 1'b1;
    mac_rx = '0;
    local_enable = 1'b1;
    app_rx_ack = 1'b0;
    app_rx_overrun_ack = 1'b0;
    good = '{dmac: my_mac, etype: 16'h0800, ver: 8'h45, proto: 8'h11, dip: my_ip, dport: my_port};
    repeat (4) @(posedge mac_clk);
    #1;
    mac_rst = 1'b0;
    consume = 1'b1;

    // rejected frames, then a disabled receiver, then a good one
    for (int k = 0; k < 6; k++) begin
      send_frame(corrupt(good, k), 2, 1'b0, 1'b0);
    end
    local_enable = 1'b0;
    send_frame(good, 2, 1'b0, 1'b0);
    local_enable = 1'b1;
    send_frame(good, 3, 1'b0, 1'b1);
    wait_drain();

    // unicast to this station
    send_frame(good, 4, 1'b0, 1'b1);
    wait_drain();

    // broadcast, then multicast group inside the mask
    h = good;
    h.dmac = {48{1'b1}};
    send_frame(h, 2, 1'b0, 1'b1);
    h.dmac = 48'h01_00_5e_01_02_03;
    h.dip = 32'hef01_0203;
    send_frame(h, 3, 1'b0, 1'b1);
    // bad mark on the last beat
    send_frame(good, 2, 1'b1, 1'b1);
    wait_drain();

    // fill the fifo with acks held back
    consume = 1'b0;
    overrun_allowed = 1'b1;
    popped = 0;
    repeat (5) send_frame(good, 8, 1'b0, 1'b1);
    consume = 1'b1;
    wait_drain();
    overrun_found: assert (overrun_seen) else begin
      $display("no overrun entry after %0d entries with acks held back", popped);
      $display("Simulation failed");
      $fatal(1);
    end
    // still in overrun, nothing may come out
    send_frame(good, 2, 1'b0, 1'b0);
    wait_drain();
    @(posedge mac_clk);
    #1;
    app_rx_overrun_ack = 1'b1;
    @(posedge mac_clk);
    #1;
    app_rx_overrun_ack = 1'b0;
    overrun_allowed = 1'b0;
    send_frame(good, 3, 1'b0, 1'b1);
    wait_drain();

    // reset while entries are still buffered, they must all be gone
    consume = 1'b0;
    send_frame(good, 3, 1'b0, 1'b0);
    mac_rst = 1'b1;
    repeat (4) @(posedge mac_clk);
    #1;
    mac_rst = 1'b0;
    consume = 1'b1;
    wait_drain();

    if (i_dut.i_props.fail_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

// ==== all.f ====
rtl/udp_rx_pkg.sv
rtl/rx_beat_tracker.sv
rtl/eth_addr_filter.sv
rtl/ip_udp_filter.sv
rtl/rx_frame_router.sv
rtl/rx_packet_fifo.sv
rtl/udp_rx.sv
tests/udp_rx_properties.sv
tests/udp_rx_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing --assert -Wall
TOP       := udp_rx_tb
FILELIST  := all.f
SIM       := obj_dir/V$(TOP)
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$($(SIM) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
